//--- logic/ptw_pkg.sv
// ------------------------------------------------
// Sv32 page-table walker shared definitions
// widths, vector types, entry flag positions and
// the walker state encodings
// ------------------------------------------------

package ptw_pkg;

    // ------------------------------------------------
    // address and field widths
    // ------------------------------------------------
    // virtual address
    localparam int VLEN  = 32;
    // physical address, Sv32 allows 34 bits
    localparam int PLEN  = 34;
    // physical page number
    localparam int PPNW  = 22;
    // address space id
    localparam int ASIDW = 9;
    // full virtual page number, both levels
    localparam int VPNW  = 20;

    // page offset width, 4 KiB pages
    localparam int PG_OFFW     = 12;
    // one level of the VPN indexes 1024 entries
    localparam int VPN_LVLW    = 10;
    // ppn starts above the flag and rsw bits
    localparam int PTE_PPN_LSB = 10;

    // ------------------------------------------------
    // page table entry flag positions
    // ------------------------------------------------
    localparam int PTE_V = 0;
    localparam int PTE_R = 1;
    localparam int PTE_W = 2;
    localparam int PTE_X = 3;
    localparam int PTE_U = 4;
    localparam int PTE_G = 5;
    localparam int PTE_A = 6;
    localparam int PTE_D = 7;

    // vectors with a meaning
    typedef logic [VLEN-1:0]  vaddr_t;
    typedef logic [PLEN-1:0]  paddr_t;
    typedef logic [PPNW-1:0]  ppn_t;
    typedef logic [ASIDW-1:0] asid_t;
    typedef logic [VPNW-1:0]  vpn_t;
    // raw entry as it comes back from memory
    typedef logic [31:0]      pte_t;

    // ------------------------------------------------
    // walker state machine
    // ------------------------------------------------
    typedef enum logic [2:0] {
        IDLE,
        WAIT_GRANT,
        PTE_LOOKUP,
        WAIT_RVALID,
        PROPAGATE_ERROR,
        LATENCY
    } ptw_state_e;

    // Sv32 has two levels, LVL1 is the root table
    typedef enum logic {
        LVL1,
        LVL2
    } ptw_lvl_e;

endpackage

//--- logic/ptw_ctrl.sv
// ------------------------------------------------
// page-table walker controller
// sequences the memory reads, tracks the level,
// applies the flush rule and issues the result pulses
// ------------------------------------------------

module ptw_ctrl import ptw_pkg::*; (
    input  logic     clk_i,
    input  logic     rst_ni,
    input  logic     flush_i,
    // walk start from the shared TLB
    input  logic     shared_tlb_access_i,
    input  logic     shared_tlb_hit_i,
    input  logic     itlb_req_i,
    // memory grant
    input  logic     mem_gnt_i,
    // classified entry from the checker
    input  logic     rvalid_q,
    input  logic     pte_fault,
    input  logic     pte_leaf,
    // memory strobes
    output logic     mem_req_o,
    output logic     mem_tag_valid_o,
    // walk register controls
    output logic     start_walk_o,
    output logic     descend_o,
    output logic     pte_seen_o,
    // result and status
    output logic     tlb_update_valid_o,
    output logic     ptw_error_o,
    output logic     ptw_active_o,
    output logic     walking_instr_o,
    output ptw_lvl_e lvl_o
);

    ptw_state_e state_q, state_d;
    ptw_lvl_e   lvl_q, lvl_d;
    // instruction walk flag, latched at walk start
    logic       is_instr_q, is_instr_d;
    // tag valid follows the grant by one cycle
    logic       tag_valid_q, tag_valid_d;
    logic       tlb_miss;
    // a read has been granted and its data is not back yet
    logic       read_pending;

    assign tlb_miss        = shared_tlb_access_i & ~shared_tlb_hit_i;
    assign ptw_active_o    = (state_q != IDLE);
    assign walking_instr_o = is_instr_q;
    assign mem_tag_valid_o = tag_valid_q;
    assign lvl_o           = lvl_q;

    assign read_pending = ((state_q == PTE_LOOKUP || state_q == WAIT_RVALID) && !rvalid_q)
                        || (state_q == WAIT_GRANT && mem_gnt_i);

    // ------------------------------------------------
    // next state
    // ------------------------------------------------
    always_comb begin
        state_d            = state_q;
        lvl_d              = lvl_q;
        is_instr_d         = is_instr_q;
        tag_valid_d        = 1'b0;
        mem_req_o          = 1'b0;
        start_walk_o       = 1'b0;
        descend_o          = 1'b0;
        pte_seen_o         = 1'b0;
        tlb_update_valid_o = 1'b0;
        ptw_error_o        = 1'b0;

        case (state_q)
            IDLE: begin
                // every walk starts at the root table
                lvl_d      = LVL1;
                is_instr_d = 1'b0;
                if (tlb_miss && !flush_i) begin
                    start_walk_o = 1'b1;
                    is_instr_d   = itlb_req_i;
                    state_d      = WAIT_GRANT;
                end
            end
            WAIT_GRANT: begin
                // request level held until the grant
                mem_req_o = 1'b1;
                if (mem_gnt_i) begin
                    tag_valid_d = 1'b1;
                    state_d     = PTE_LOOKUP;
                end
            end
            PTE_LOOKUP: begin
                if (rvalid_q) begin
                    pte_seen_o = 1'b1;
                    if (pte_fault) begin
                        state_d = PROPAGATE_ERROR;
                    end else if (pte_leaf) begin
                        tlb_update_valid_o = 1'b1;
                        state_d            = LATENCY;
                    end else if (lvl_q == LVL1) begin
                        // pointer, go down to the second table
                        descend_o = 1'b1;
                        lvl_d     = LVL2;
                        state_d   = WAIT_GRANT;
                    end else begin
                        // pointer in the last table has nowhere to go
                        state_d = PROPAGATE_ERROR;
                    end
                end
            end
            PROPAGATE_ERROR: begin
                ptw_error_o = 1'b1;
                state_d     = LATENCY;
            end
            WAIT_RVALID: begin
                // drain the read left behind by a flush
                if (rvalid_q) begin
                    state_d = IDLE;
                end
            end
            LATENCY: begin
                state_d = IDLE;
            end
            default: begin
                state_d = IDLE;
            end
        endcase

        // ------------------------------------------------
        // flush
        // ------------------------------------------------
        // a flushed walk reports nothing, an open read must still return
        if (flush_i) begin
            tlb_update_valid_o = 1'b0;
            ptw_error_o        = 1'b0;
            if (read_pending) begin
                state_d = WAIT_RVALID;
            end else begin
                state_d = LATENCY;
            end
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q     <= IDLE;
            lvl_q       <= LVL1;
            is_instr_q  <= 1'b0;
            tag_valid_q <= 1'b0;
        end else begin
            state_q     <= state_d;
            lvl_q       <= lvl_d;
            is_instr_q  <= is_instr_d;
            tag_valid_q <= tag_valid_d;
        end
    end

    // a walk ends in one result, never both at once
    a_update_no_error: assert property (@(posedge clk_i) disable iff (!rst_ni)
        !(tlb_update_valid_o && ptw_error_o))
        else $error("ptw update and error pulses overlap");

    // request level is held until the memory grants it
    a_req_held: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (mem_req_o && !mem_gnt_i && !flush_i) |=> mem_req_o)
        else $error("ptw memory request dropped before grant");

endmodule

//--- logic/pte_check.sv
// ------------------------------------------------
// page table entry checker
// registers the memory response and classifies the
// entry as fault, leaf or pointer by the Sv32 rules
// ------------------------------------------------

module pte_check import ptw_pkg::*; (
    input  logic     clk_i,
    input  logic     rst_ni,
    // memory response
    input  logic     mem_rvalid_i,
    input  pte_t     mem_rdata_i,
    // walk context
    input  ptw_lvl_e lvl_i,
    input  logic     is_instr_i,
    input  logic     lsu_is_store_i,
    input  logic     mxr_i,
    // registered entry and its classification
    output logic     rvalid_q_o,
    output pte_t     pte_q_o,
    output logic     pte_fault_o,
    output logic     pte_leaf_o
);

    logic rvalid_q;
    pte_t pte_q;

    // decoded flags
    logic flag_v;
    logic flag_r;
    logic flag_w;
    logic flag_x;
    logic flag_a;
    logic flag_d;

    logic pte_invalid;
    logic is_leaf;
    logic instr_fail;
    logic data_fail;
    logic store_fail;
    logic misaligned;
    logic perm_fail;

    // ------------------------------------------------
    // response register
    // ------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            rvalid_q <= 1'b0;
        end else begin
            rvalid_q <= mem_rvalid_i;
        end
    end

    // entry only captured with its strobe
    always_ff @(posedge clk_i) begin
        if (mem_rvalid_i) begin
            pte_q <= mem_rdata_i;
        end
    end

    assign flag_v = pte_q[PTE_V];
    assign flag_r = pte_q[PTE_R];
    assign flag_w = pte_q[PTE_W];
    assign flag_x = pte_q[PTE_X];
    assign flag_a = pte_q[PTE_A];
    assign flag_d = pte_q[PTE_D];

    // ------------------------------------------------
    // classification
    // ------------------------------------------------
    // not valid, or write without read, is reserved
    assign pte_invalid = !flag_v || (!flag_r && flag_w);
    assign is_leaf     = !pte_invalid && (flag_r || flag_x);

    // fetch needs execute and accessed
    assign instr_fail = !flag_x || !flag_a;
    // load needs accessed and read, or execute with mxr
    assign data_fail  = !flag_a || !(flag_r || (flag_x && mxr_i));
    // store also needs write and dirty
    assign store_fail = lsu_is_store_i && (!flag_w || !flag_d);

    assign perm_fail = is_instr_i ? instr_fail : (data_fail || store_fail);

    // superpage must have the low ppn half clear
    assign misaligned = (lvl_i == LVL1) && (pte_q[PTE_PPN_LSB +: VPN_LVLW] != '0);

    assign rvalid_q_o  = rvalid_q;
    assign pte_q_o     = pte_q;
    assign pte_fault_o = pte_invalid || (is_leaf && (perm_fail || misaligned));
    assign pte_leaf_o  = is_leaf;

    // an entry that fails the validity check is a fault and never a leaf
    a_invalid_not_leaf: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (mem_rvalid_i && !mem_rdata_i[PTE_V]) |=> (pte_fault_o && !pte_leaf_o))
        else $error("invalid entry classified as leaf");

endmodule

//--- logic/ptw_walk_regs.sv
// ------------------------------------------------
// walk context registers
// holds the request, builds the table pointers and
// assembles the shared TLB update fields
// ------------------------------------------------

module ptw_walk_regs import ptw_pkg::*; (
    input  logic     clk_i,
    input  logic     rst_ni,
    // controls from the walker FSM
    input  logic     start_walk_i,
    input  logic     descend_i,
    input  logic     pte_seen_i,
    // request context
    input  vaddr_t   shared_tlb_vaddr_i,
    input  asid_t    asid_i,
    input  ppn_t     satp_ppn_i,
    // current entry and level
    input  pte_t     pte_i,
    input  ptw_lvl_e lvl_i,
    // table pointer to memory
    output paddr_t   mem_addr_o,
    // TLB update fields
    output vaddr_t   update_vaddr_o,
    output vpn_t     tlb_update_vpn_o,
    output asid_t    tlb_update_asid_o,
    output logic     tlb_update_is_4m_o,
    output pte_t     tlb_update_content_o
);

    vaddr_t vaddr_q;
    asid_t  asid_q;
    paddr_t pptr_q;
    // global bit seen anywhere on the walk
    logic   global_q;
    pte_t   content;

    // ------------------------------------------------
    // request context
    // ------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (start_walk_i) begin
            vaddr_q <= shared_tlb_vaddr_i;
            asid_q  <= asid_i;
        end
    end

    // ------------------------------------------------
    // pointer and global accumulation
    // ------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            pptr_q   <= '0;
            global_q <= 1'b0;
        end else begin
            if (start_walk_i) begin
                // root table base plus VPN[1] times 4
                pptr_q   <= {satp_ppn_i, shared_tlb_vaddr_i[VLEN-1 -: VPN_LVLW], 2'b00};
                global_q <= 1'b0;
            end else begin
                if (descend_i) begin
                    // next table base from the pointer entry plus VPN[0] times 4
                    pptr_q <= {pte_i[31:PTE_PPN_LSB], vaddr_q[PG_OFFW +: VPN_LVLW], 2'b00};
                end
                if (pte_seen_i) begin
                    global_q <= global_q | pte_i[PTE_G];
                end
            end
        end
    end

    // leaf entry with the global bit of the whole walk folded in
    always_comb begin
        content        = pte_i;
        content[PTE_G] = pte_i[PTE_G] | global_q;
    end

    assign mem_addr_o           = pptr_q;
    assign update_vaddr_o       = vaddr_q;
    assign tlb_update_vpn_o     = vaddr_q[VLEN-1:PG_OFFW];
    assign tlb_update_asid_o    = asid_q;
    // a leaf found in the root table maps 4 MiB
    assign tlb_update_is_4m_o   = (lvl_i == LVL1);
    assign tlb_update_content_o = content;

    // table pointers always address a whole entry
    a_ptr_aligned: assert property (@(posedge clk_i) disable iff (!rst_ni)
        mem_addr_o[1:0] == 2'b00)
        else $error("table pointer not word aligned");

endmodule

//--- logic/ptw_sv32.sv
// ------------------------------------------------
// Sv32 hardware page-table walker
// walks one or two levels on a shared TLB miss and
// returns a TLB update or a page fault
// ------------------------------------------------

module ptw_sv32 import ptw_pkg::*; (
    input  logic   clk_i,
    input  logic   rst_ni,
    // control and status
    input  logic   flush_i,
    output logic   ptw_active_o,
    output logic   walking_instr_o,
    // walk start
    input  logic   shared_tlb_access_i,
    input  logic   shared_tlb_hit_i,
    input  vaddr_t shared_tlb_vaddr_i,
    input  logic   itlb_req_i,
    input  asid_t  asid_i,
    input  ppn_t   satp_ppn_i,
    // permission check inputs
    input  logic   mxr_i,
    input  logic   lsu_is_store_i,
    // memory read port
    output logic   mem_req_o,
    input  logic   mem_gnt_i,
    output paddr_t mem_addr_o,
    output logic   mem_tag_valid_o,
    input  logic   mem_rvalid_i,
    input  pte_t   mem_rdata_i,
    // shared TLB update
    output logic   tlb_update_valid_o,
    output vpn_t   tlb_update_vpn_o,
    output asid_t  tlb_update_asid_o,
    output logic   tlb_update_is_4m_o,
    output pte_t   tlb_update_content_o,
    output vaddr_t update_vaddr_o,
    // page fault
    output logic   ptw_error_o
);

    logic     start_walk;
    logic     descend;
    logic     pte_seen;
    logic     rvalid_q;
    logic     pte_fault;
    logic     pte_leaf;
    pte_t     pte_q;
    ptw_lvl_e lvl;

    ptw_ctrl u_ptw_ctrl (
        .clk_i               (clk_i),
        .rst_ni              (rst_ni),
        .flush_i             (flush_i),
        .shared_tlb_access_i (shared_tlb_access_i),
        .shared_tlb_hit_i    (shared_tlb_hit_i),
        .itlb_req_i          (itlb_req_i),
        .mem_gnt_i           (mem_gnt_i),
        .rvalid_q            (rvalid_q),
        .pte_fault           (pte_fault),
        .pte_leaf            (pte_leaf),
        .mem_req_o           (mem_req_o),
        .mem_tag_valid_o     (mem_tag_valid_o),
        .start_walk_o        (start_walk),
        .descend_o           (descend),
        .pte_seen_o          (pte_seen),
        .tlb_update_valid_o  (tlb_update_valid_o),
        .ptw_error_o         (ptw_error_o),
        .ptw_active_o        (ptw_active_o),
        .walking_instr_o     (walking_instr_o),
        .lvl_o               (lvl)
    );

    pte_check u_pte_check (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .mem_rvalid_i   (mem_rvalid_i),
        .mem_rdata_i    (mem_rdata_i),
        .lvl_i          (lvl),
        .is_instr_i     (walking_instr_o),
        .lsu_is_store_i (lsu_is_store_i),
        .mxr_i          (mxr_i),
        .rvalid_q_o     (rvalid_q),
        .pte_q_o        (pte_q),
        .pte_fault_o    (pte_fault),
        .pte_leaf_o     (pte_leaf)
    );

    ptw_walk_regs u_ptw_walk_regs (
        .clk_i                (clk_i),
        .rst_ni               (rst_ni),
        .start_walk_i         (start_walk),
        .descend_i            (descend),
        .pte_seen_i           (pte_seen),
        .shared_tlb_vaddr_i   (shared_tlb_vaddr_i),
        .asid_i               (asid_i),
        .satp_ppn_i           (satp_ppn_i),
        .pte_i                (pte_q),
        .lvl_i                (lvl),
        .mem_addr_o           (mem_addr_o),
        .update_vaddr_o       (update_vaddr_o),
        .tlb_update_vpn_o     (tlb_update_vpn_o),
        .tlb_update_asid_o    (tlb_update_asid_o),
        .tlb_update_is_4m_o   (tlb_update_is_4m_o),
        .tlb_update_content_o (tlb_update_content_o)
    );

endmodule

//--- sim/tb_ptw_sv32.sv
// ------------------------------------------------
// directed testbench for the Sv32 page-table walker
// page-table memory model with random grant and
// read latency, one task per walk scenario
// ------------------------------------------------

module tb_ptw_sv32 import ptw_pkg::*; ();

    // two reads of at most 4+4 cycles plus lookup and latency give about 25 cycles
    // per walk, 13 walks in the run, so 2000 leaves a wide margin
    localparam int    CYCLE_LIMIT = 2000;
    localparam ppn_t  SATP_PPN    = 22'h00100;
    localparam ppn_t  PTR_PPN     = 22'h00200;
    localparam asid_t ASID        = 9'h05;

    // entry flag masks
    localparam logic [7:0] F_V = 8'(1 << PTE_V);
    localparam logic [7:0] F_R = 8'(1 << PTE_R);
    localparam logic [7:0] F_W = 8'(1 << PTE_W);
    localparam logic [7:0] F_X = 8'(1 << PTE_X);
    localparam logic [7:0] F_G = 8'(1 << PTE_G);
    localparam logic [7:0] F_A = 8'(1 << PTE_A);
    localparam logic [7:0] F_D = 8'(1 << PTE_D);

    // ------------------------------------------------
    // DUT signals
    // ------------------------------------------------
    logic   clk_i = 1'b0;
    logic   rst_ni;
    logic   flush_i;
    logic   shared_tlb_access_i;
    logic   shared_tlb_hit_i;
    vaddr_t shared_tlb_vaddr_i;
    logic   itlb_req_i;
    asid_t  asid_i;
    ppn_t   satp_ppn_i;
    logic   mxr_i;
    logic   lsu_is_store_i;
    // memory side, driven by the model
    logic   mem_gnt_i    = 1'b0;
    logic   mem_rvalid_i = 1'b0;
    pte_t   mem_rdata_i  = '0;

    logic   ptw_active_o;
    logic   walking_instr_o;
    logic   mem_req_o;
    paddr_t mem_addr_o;
    logic   mem_tag_valid_o;
    logic   tlb_update_valid_o;
    vpn_t   tlb_update_vpn_o;
    asid_t  tlb_update_asid_o;
    logic   tlb_update_is_4m_o;
    pte_t   tlb_update_content_o;
    vaddr_t update_vaddr_o;
    logic   ptw_error_o;

    // page-table memory model state
    pte_t   mem_model [paddr_t];
    integer seed       = 88;
    int     gnt_wait   = 0;
    int     rd_wait    = 0;
    logic   rd_pending = 1'b0;
    paddr_t rd_addr    = '0;
    // longest read latency on every grant
    logic   slow_read  = 1'b0;

    // result monitor
    int     upd_total = 0;
    int     err_total = 0;
    vpn_t   upd_vpn;
    asid_t  upd_asid;
    logic   upd_is_4m;
    pte_t   upd_content;
    vaddr_t upd_vaddr;
    paddr_t seen_addr [$];
    // a grant happened in the previous cycle
    logic   gnt_q     = 1'b0;

    // run bookkeeping
    int     cycle_cnt = 0;
    int     errs = 0;
    int     tests_pass = 0;
    int     tests_fail = 0;
    int     upd_before;
    int     err_before;
    int     upd_delta;
    int     err_delta;
    int     instr_mismatch;
    logic   cur_instr;

    ptw_sv32 u_ptw_sv32 (.*);

    always #5 clk_i = ~clk_i;

    // ------------------------------------------------
    // page-table memory model
    // ------------------------------------------------
    // unmapped addresses read back as an invalid entry
    function automatic pte_t read_entry(input paddr_t addr);
        if (mem_model.exists(addr)) begin
            return mem_model[addr];
        end
        return '0;
    endfunction

    always @(posedge clk_i) begin
        mem_gnt_i    <= 1'b0;
        mem_rvalid_i <= 1'b0;
        // data comes back 1 to 4 cycles after the grant
        if (rd_pending) begin
            if (rd_wait == 0) begin
                mem_rvalid_i <= 1'b1;
                mem_rdata_i  <= read_entry(rd_addr);
                rd_pending   <= 1'b0;
            end else begin
                rd_wait <= rd_wait - 1;
            end
        end
        // a request not yet granted waits 0 to 3 extra cycles
        if (mem_req_o && !mem_gnt_i) begin
            if (gnt_wait == 0) begin
                mem_gnt_i  <= 1'b1;
                rd_pending <= 1'b1;
                rd_addr    <= mem_addr_o;
                rd_wait    <= slow_read ? 3 : $unsigned($random(seed)) % 4;
                gnt_wait   <= $unsigned($random(seed)) % 4;
            end else begin
                gnt_wait <= gnt_wait - 1;
            end
        end
    end

    // pulse counts, update fields and granted read addresses
    always @(posedge clk_i) begin
        if (tlb_update_valid_o) begin
            upd_total   <= upd_total + 1;
            upd_vpn     <= tlb_update_vpn_o;
            upd_asid    <= tlb_update_asid_o;
            upd_is_4m   <= tlb_update_is_4m_o;
            upd_content <= tlb_update_content_o;
            upd_vaddr   <= update_vaddr_o;
        end
        if (ptw_error_o) begin
            err_total <= err_total + 1;
        end
        if (mem_req_o && mem_gnt_i) begin
            seen_addr.push_back(mem_addr_o);
        end
        // tag valid marks exactly the cycle after each grant
        if (mem_tag_valid_o !== gnt_q) begin
            $display("FAILED mem_tag_valid_o: got %h expected %h", mem_tag_valid_o, gnt_q);
            errs++;
        end
        gnt_q <= mem_req_o && mem_gnt_i;
    end

    // run limit
    always @(posedge clk_i) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            $display("timeout: the run did not end within %0d cycles", CYCLE_LIMIT);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    // ------------------------------------------------
    // expected values from the Sv32 rules
    // ------------------------------------------------
    // ppn above the two reserved bits and the flags
    function automatic pte_t make_pte(input ppn_t ppn, input logic [7:0] flags);
        return {ppn, 2'b00, flags};
    endfunction

    // root entry: satp base, VPN[1] word index
    function automatic paddr_t root_addr(input vaddr_t va);
        return {SATP_PPN, va[31:22], 2'b00};
    endfunction

    // second level entry: pointer base, VPN[0] word index
    function automatic paddr_t next_addr(input ppn_t ppn, input vaddr_t va);
        return {ppn, va[21:12], 2'b00};
    endfunction

    // ------------------------------------------------
    // helpers
    // ------------------------------------------------
    task automatic check_hex(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            $display("FAILED %s: got %h expected %h", name, got, exp);
            errs++;
        end
    endtask

    task automatic report_test(input string name, input int errs_at_start);
        if (errs == errs_at_start) begin
            tests_pass++;
            $display("test %s: ok", name);
        end else begin
            tests_fail++;
            $display("test %s: %0d errors", name, errs - errs_at_start);
        end
    endtask

    // one cycle of shared TLB miss, context held for the walk
    task automatic start_miss(input vaddr_t va, input logic instr, input logic store,
                              input logic mxr);
        upd_before = upd_total;
        err_before = err_total;
        seen_addr.delete();
        cur_instr = instr;
        shared_tlb_access_i <= 1'b1;
        shared_tlb_hit_i    <= 1'b0;
        shared_tlb_vaddr_i  <= va;
        itlb_req_i          <= instr;
        lsu_is_store_i      <= store;
        mxr_i               <= mxr;
        @(posedge clk_i);
        shared_tlb_access_i <= 1'b0;
    endtask

    // walker back to idle, walking_instr_o watched while active
    task automatic finish_walk;
        instr_mismatch = 0;
        do begin
            @(posedge clk_i);
            if (ptw_active_o && (walking_instr_o !== cur_instr)) begin
                instr_mismatch++;
            end
        end while (ptw_active_o);
        upd_delta = upd_total - upd_before;
        err_delta = err_total - err_before;
    endtask

    task automatic run_walk(input vaddr_t va, input logic instr, input logic store,
                            input logic mxr);
        start_miss(va, instr, store, mxr);
        finish_walk();
    endtask

    task automatic expect_outcome(input int exp_upd, input int exp_err);
        check_hex("tlb_update_valid_o pulses", 64'(upd_delta), 64'(exp_upd));
        check_hex("ptw_error_o pulses", 64'(err_delta), 64'(exp_err));
        if (instr_mismatch != 0) begin
            $display("walking_instr_o did not follow itlb_req_i for %0d cycles",
                     instr_mismatch);
            errs++;
        end
    endtask

    task automatic check_update(input vaddr_t va, input pte_t exp_content, input logic exp_4m);
        check_hex("tlb_update_vpn_o", 64'(upd_vpn), 64'(va[31:12]));
        check_hex("tlb_update_asid_o", 64'(upd_asid), 64'(ASID));
        check_hex("tlb_update_is_4m_o", 64'(upd_is_4m), 64'(exp_4m));
        check_hex("tlb_update_content_o", 64'(upd_content), 64'(exp_content));
        check_hex("update_vaddr_o", 64'(upd_vaddr), 64'(va));
    endtask

    // single entry in the root table, walk ends there
    task automatic superpage_case(input pte_t leaf, input logic instr, input logic store,
                                  input logic mxr, input int exp_upd, input int exp_err);
        vaddr_t va;
        va = 32'h8000_0000;
        mem_model.delete();
        mem_model[root_addr(va)] = leaf;
        run_walk(va, instr, store, mxr);
        expect_outcome(exp_upd, exp_err);
    endtask

    // ------------------------------------------------
    // tests
    // ------------------------------------------------
    task automatic test_reset_and_instr;
        vaddr_t va;
        int     e0;
        e0 = errs;
        va = 32'h0040_0000;
        check_hex("mem_req_o", 64'(mem_req_o), 64'h0);
        check_hex("mem_tag_valid_o", 64'(mem_tag_valid_o), 64'h0);
        check_hex("tlb_update_valid_o", 64'(tlb_update_valid_o), 64'h0);
        check_hex("ptw_error_o", 64'(ptw_error_o), 64'h0);
        check_hex("ptw_active_o", 64'(ptw_active_o), 64'h0);
        // fetch from an executable superpage
        mem_model.delete();
        mem_model[root_addr(va)] = make_pte(22'h3FC00, F_V | F_X | F_A);
        run_walk(va, 1'b1, 1'b0, 1'b0);
        expect_outcome(1, 0);
        report_test("reset_and_instr_walk", e0);
    endtask

    task automatic test_two_level;
        vaddr_t va;
        pte_t   leaf;
        int     e0;
        e0 = errs;
        va = 32'h1234_5678;
        leaf = make_pte(22'h3ABCD, F_V | F_R | F_W | F_A | F_D);
        mem_model.delete();
        mem_model[root_addr(va)] = make_pte(PTR_PPN, F_V);
        mem_model[next_addr(PTR_PPN, va)] = leaf;
        run_walk(va, 1'b0, 1'b0, 1'b0);
        expect_outcome(1, 0);
        check_update(va, leaf, 1'b0);
        if (seen_addr.size() != 2) begin
            $display("expected two memory reads, saw %0d", seen_addr.size());
            errs++;
        end else begin
            check_hex("mem_addr_o", 64'(seen_addr[0]), 64'(root_addr(va)));
            check_hex("mem_addr_o", 64'(seen_addr[1]), 64'(next_addr(PTR_PPN, va)));
        end
        report_test("two_level_walk", e0);
    endtask

    task automatic test_superpage;
        pte_t leaf;
        int   e0;
        e0 = errs;
        leaf = make_pte(22'h3FC00, F_V | F_R | F_A);
        superpage_case(leaf, 1'b0, 1'b0, 1'b0, 1, 0);
        check_update(32'h8000_0000, leaf, 1'b1);
        // low ppn half set on a 4 MiB leaf
        superpage_case(make_pte(22'h3FC01, F_V | F_R | F_A), 1'b0, 1'b0, 1'b0, 0, 1);
        report_test("superpage", e0);
    endtask

    task automatic test_permissions;
        int e0;
        e0 = errs;
        // fetch without execute
        superpage_case(make_pte(22'h00400, F_V | F_R | F_A), 1'b1, 1'b0, 1'b0, 0, 1);
        // load from execute-only, then the same with mxr
        superpage_case(make_pte(22'h00400, F_V | F_X | F_A), 1'b0, 1'b0, 1'b0, 0, 1);
        superpage_case(make_pte(22'h00400, F_V | F_X | F_A), 1'b0, 1'b0, 1'b1, 1, 0);
        // store without dirty
        superpage_case(make_pte(22'h00400, F_V | F_R | F_W | F_A), 1'b0, 1'b1, 1'b0, 0, 1);
        // valid bit clear
        superpage_case(make_pte(22'h00400, F_R | F_A), 1'b0, 1'b0, 1'b0, 0, 1);
        report_test("permission_faults", e0);
    endtask

    task automatic test_global;
        vaddr_t va;
        pte_t   leaf;
        int     e0;
        e0 = errs;
        va = 32'h00C0_3000;
        leaf = make_pte(22'h01234, F_V | F_R | F_A);
        mem_model.delete();
        mem_model[root_addr(va)] = make_pte(PTR_PPN, F_V | F_G);
        mem_model[next_addr(PTR_PPN, va)] = leaf;
        run_walk(va, 1'b0, 1'b0, 1'b0);
        expect_outcome(1, 0);
        check_update(va, leaf | 32'(F_G), 1'b0);
        // pointer again in the second table
        mem_model[next_addr(PTR_PPN, va)] = make_pte(22'h00300, F_V);
        run_walk(va, 1'b0, 1'b0, 1'b0);
        expect_outcome(0, 1);
        report_test("global_and_lvl2_pointer", e0);
    endtask

    task automatic test_flush;
        vaddr_t va;
        pte_t   leaf;
        int     e0;
        e0 = errs;
        va = 32'h2345_6000;
        leaf = make_pte(22'h00777, F_V | F_R | F_A);
        mem_model.delete();
        mem_model[root_addr(va)] = make_pte(PTR_PPN, F_V);
        mem_model[next_addr(PTR_PPN, va)] = leaf;
        // data held back long enough to outlast the flush
        slow_read = 1'b1;
        start_miss(va, 1'b0, 1'b0, 1'b0);
        // flush right after the first grant, data still out
        do begin
            @(posedge clk_i);
        end while (!mem_gnt_i);
        flush_i <= 1'b1;
        @(posedge clk_i);
        flush_i <= 1'b0;
        finish_walk();
        slow_read = 1'b0;
        expect_outcome(0, 0);
        // walker must not be idle before the flushed read is back
        if (rd_pending || mem_rvalid_i) begin
            $display("walker went idle while the flushed read was still outstanding");
            errs++;
        end
        // next miss walks normally
        run_walk(va, 1'b0, 1'b0, 1'b0);
        expect_outcome(1, 0);
        check_update(va, leaf, 1'b0);
        report_test("flush_during_read", e0);
    endtask

    // ------------------------------------------------
    // main sequence
    // ------------------------------------------------
    initial begin
        rst_ni              = 1'b0;
        flush_i             = 1'b0;
        shared_tlb_access_i = 1'b0;
        shared_tlb_hit_i    = 1'b0;
        shared_tlb_vaddr_i  = '0;
        itlb_req_i          = 1'b0;
        asid_i              = ASID;
        satp_ppn_i          = SATP_PPN;
        mxr_i               = 1'b0;
        lsu_is_store_i      = 1'b0;
        cur_instr           = 1'b0;
        repeat (3) @(posedge clk_i);
        rst_ni <= 1'b1;
        @(posedge clk_i);

        test_reset_and_instr();
        test_two_level();
        test_superpage();
        test_permissions();
        test_global();
        test_flush();

        $display("tests passed %0d, failed %0d", tests_pass, tests_fail);
        if (tests_fail == 0 && errs == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

//--- files.f
logic/ptw_pkg.sv
logic/ptw_ctrl.sv
logic/pte_check.sv
logic/ptw_walk_regs.sv
logic/ptw_sv32.sv
sim/tb_ptw_sv32.sv

//--- Makefile
TOP = tb_ptw_sv32

.PHONY: all lint clean

all:
	verilator --binary --timing --assert -f files.f --top-module $(TOP) -Mdir obj_dir
	out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -qx "SIMULATION PASSED"

lint:
	verilator --lint-only --timing --assert -f files.f --top-module ptw_sv32
	verilator --lint-only --timing --assert -f files.f --top-module $(TOP)

clean:
	rm -rf obj_dir
